//--- design/mmio_cpl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes, the CplD format code and the
// request, response and completion beat structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mmio_cpl_pkg;

    // Every tag in flight owns one slot of the request metadata memory
    localparam int MAX_OUTSTANDING_READS = 32;
    localparam int TAG_W = $clog2(MAX_OUTSTANDING_READS);

    // MMIO reads return at most two dwords
    localparam int PAYLOAD_W = 64;

    // Format/type of a completion with data, 3 dword header
    localparam logic [7:0] FMTTYPE_CPLD = 8'b0100_1010;

    typedef logic [TAG_W-1:0] mmio_tag_t;

    // Request details kept until the accelerator answers
    typedef struct packed {
        mmio_tag_t   tag;
        logic [15:0] requester_id;
        logic [2:0]  tc;
        logic [6:0]  lower_addr;
        logic [11:0] byte_count;
    } mmio_host_req_t;

    typedef struct packed {
        mmio_tag_t              tag;
        logic [PAYLOAD_W-1:0]   payload;
    } mmio_afu_rsp_t;

    // Only the completion fields that the generator fills in
    typedef struct packed {
        logic [7:0]  fmttype;
        logic [9:0]  length;
        logic [11:0] byte_count;
        logic [15:0] requester_id;
        logic [2:0]  tc;
        logic [6:0]  lower_addr;
        mmio_tag_t   tag;
    } cpl_hdr_t;

    // A completion always fits in a single beat
    typedef struct packed {
        cpl_hdr_t               hdr;
        logic [PAYLOAD_W-1:0]   data;
        logic [1:0]             dw_keep;
    } cpl_beat_t;

endpackage

//--- design/sync_fifo2.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry FIFO, entry type given as a type parameter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sync_fifo2 #(
    parameter type entry_t = logic
) (
    input  logic   clk,
    input  logic   reset_n,

    input  logic   enq_en,
    input  entry_t enq_data,
    output logic   not_full,

    input  logic   deq_en,
    output entry_t first,
    output logic   not_empty
);

    // Slot 0 always holds the oldest entry, slot 1 the one behind it
    entry_t data_0;
    entry_t data_1;
    logic   valid_0;
    logic   valid_1;

    // Both flags come straight from registers
    assign first     = data_0;
    assign not_empty = valid_0;
    assign not_full  = !valid_1;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            valid_0 <= 1'b0;
            valid_1 <= 1'b0;
        end
        else if (deq_en && !enq_en)
        begin
            // Slot 1 moves up, if it holds anything
            valid_0 <= valid_1;
            valid_1 <= 1'b0;
        end
        else if (enq_en && !deq_en)
        begin
            valid_0 <= 1'b1;
            valid_1 <= valid_0;
        end
    end

    // The valid bits alone tell which payload slots hold live entries
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            // With slot 1 empty a simultaneous enqueue lands in slot 0 directly
            data_0 <= valid_1 ? data_1 : enq_data;
            data_1 <= enq_data;
        end
        else if (enq_en)
        begin
            if (valid_0)
                data_1 <= enq_data;
            else
                data_0 <= enq_data;
        end
    end

endmodule

//--- design/mmio_req_track.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host read request tracker with a
// tag-indexed metadata memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mmio_req_track (
    input  logic                        clk,

    // Host requests arrive as a strobe and are never stalled
    input  logic                        req_valid,
    input  mmio_cpl_pkg::mmio_host_req_t req,

    // Lookup by the tag of an accepted response
    input  mmio_cpl_pkg::mmio_tag_t     rd_tag,
    input  logic                        rd_en,

    output mmio_cpl_pkg::mmio_host_req_t rsp_meta,
    output logic                        rsp_meta_valid
);

    // One slot per tag, the tag itself is the address
    mmio_cpl_pkg::mmio_host_req_t meta_mem [mmio_cpl_pkg::MAX_OUTSTANDING_READS];

    // Request capture stage in front of the memory write port
    logic                         req_valid_q;
    mmio_cpl_pkg::mmio_host_req_t req_q;

    // Read data register of the memory, followed by the output register
    mmio_cpl_pkg::mmio_host_req_t meta_rd_q;

    // Read strobe pipeline matching the two read stages
    logic rd_en_q;

    // The strobe and the request are both registered first, so a request
    // seen at edge N lands in the memory at edge N+1
    always_ff @(posedge clk)
    begin
        req_valid_q <= req_valid;
        req_q       <= req;
    end

    always_ff @(posedge clk)
    begin
        if (req_valid_q)
        begin
            meta_mem[req_q.tag] <= req_q;
        end
    end

    // A response is accepted at least two cycles after its request,
    // so the read never races the write of the same tag
    always_ff @(posedge clk)
    begin
        meta_rd_q <= meta_mem[rd_tag];
        rsp_meta  <= meta_rd_q;
    end

    // rsp_meta_valid marks the cycle in which rsp_meta belongs to the
    // response accepted two edges earlier
    always_ff @(posedge clk)
    begin
        rd_en_q        <= rd_en;
        rsp_meta_valid <= rd_en_q;
    end

endmodule

//--- design/mmio_cpl_build.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Completion builder: response and metadata
// FIFOs, CplD header and the output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mmio_cpl_build (
    input  logic                         clk,
    input  logic                         reset_n,

    // Accelerator read responses
    input  logic                         rsp_valid,
    input  mmio_cpl_pkg::mmio_afu_rsp_t  rsp,
    output logic                         rsp_ready,

    // Metadata lookup in the request tracker
    output mmio_cpl_pkg::mmio_tag_t      rd_tag,
    output logic                         rd_en,
    input  mmio_cpl_pkg::mmio_host_req_t rsp_meta,
    input  logic                         rsp_meta_valid,

    // Completion stream
    output logic                         cpl_valid,
    output mmio_cpl_pkg::cpl_beat_t      cpl,
    input  logic                         cpl_ready
);

    mmio_cpl_pkg::mmio_afu_rsp_t  rsp_head;
    mmio_cpl_pkg::mmio_host_req_t meta_head;
    logic                         rsp_not_empty;
    logic                         meta_not_empty;
    logic                         rsp_acc;
    logic                         out_free;
    logic                         pair_deq;
    mmio_cpl_pkg::cpl_hdr_t       cpl_hdr;

    // Every accepted response starts a lookup of its own tag
    assign rsp_acc = rsp_valid && rsp_ready;
    assign rd_tag  = rsp.tag;
    assign rd_en   = rsp_acc;

    // The response and its metadata show up two cycles apart, so each
    // gets its own FIFO; the response FIFO always fills first
    sync_fifo2 #(
        .entry_t  (mmio_cpl_pkg::mmio_afu_rsp_t)
    ) afu_rsp_fifo (
        .clk      (clk),
        .reset_n  (reset_n),
        .enq_en   (rsp_acc),
        .enq_data (rsp),
        .not_full (rsp_ready),
        .deq_en   (pair_deq),
        .first    (rsp_head),
        .not_empty(rsp_not_empty)
    );

    // Metadata trails its response, so this FIFO cannot overflow
    // and its full flag is not needed
    sync_fifo2 #(
        .entry_t  (mmio_cpl_pkg::mmio_host_req_t)
    ) meta_fifo (
        .clk      (clk),
        .reset_n  (reset_n),
        .enq_en   (rsp_meta_valid),
        .enq_data (rsp_meta),
        .not_full (),
        .deq_en   (pair_deq),
        .first    (meta_head),
        .not_empty(meta_not_empty)
    );

    // The output register can take a new beat when empty or being drained
    assign out_free = cpl_ready || !cpl_valid;
    assign pair_deq = meta_not_empty && rsp_not_empty && out_free;

    always_comb
    begin
        cpl_hdr = '0;
        cpl_hdr.fmttype      = mmio_cpl_pkg::FMTTYPE_CPLD;
        // Length counts dwords, byte_count is 4 or 8
        cpl_hdr.length       = meta_head.byte_count[11:2];
        cpl_hdr.byte_count   = meta_head.byte_count;
        cpl_hdr.requester_id = meta_head.requester_id;
        cpl_hdr.tc           = meta_head.tc;
        cpl_hdr.lower_addr   = meta_head.lower_addr;
        cpl_hdr.tag          = rsp_head.tag;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cpl_valid <= 1'b0;
        end
        else if (out_free)
        begin
            cpl_valid <= pair_deq;
        end
    end

    // Beat contents change only when a new pair is taken,
    // so they hold while the sink stalls
    always_ff @(posedge clk)
    begin
        if (pair_deq)
        begin
            cpl.hdr  <= cpl_hdr;
            cpl.data <= rsp_head.payload;
            // Upper dword is enabled only for an 8 byte read
            cpl.dw_keep <= {meta_head.byte_count[3], 1'b1};
        end
    end

endmodule

//--- design/mmio_cpl_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MMIO read completion generator top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mmio_cpl_top (
    input  logic                         clk,
    input  logic                         reset_n,

    // Host read requests, accepted every cycle
    input  logic                         req_valid,
    input  mmio_cpl_pkg::mmio_host_req_t req,

    // Accelerator responses
    input  logic                         rsp_valid,
    input  mmio_cpl_pkg::mmio_afu_rsp_t  rsp,
    output logic                         rsp_ready,

    // Completions with data toward the host
    output logic                         cpl_valid,
    output mmio_cpl_pkg::cpl_beat_t      cpl,
    input  logic                         cpl_ready
);

    mmio_cpl_pkg::mmio_tag_t      rd_tag;
    logic                         rd_en;
    mmio_cpl_pkg::mmio_host_req_t rsp_meta;
    logic                         rsp_meta_valid;

    mmio_req_track mmio_req_track_i (
        .clk           (clk),
        .req_valid     (req_valid),
        .req           (req),
        .rd_tag        (rd_tag),
        .rd_en         (rd_en),
        .rsp_meta      (rsp_meta),
        .rsp_meta_valid(rsp_meta_valid)
    );

    mmio_cpl_build mmio_cpl_build_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready),
        .rd_tag        (rd_tag),
        .rd_en         (rd_en),
        .rsp_meta      (rsp_meta),
        .rsp_meta_valid(rsp_meta_valid),
        .cpl_valid     (cpl_valid),
        .cpl           (cpl),
        .cpl_ready     (cpl_ready)
    );

endmodule

//--- sim/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock (100 ns) and reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset_n
);

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    // Reset is held over the first four rising edges
    initial
    begin
        reset_n = 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

//--- sim/mmio_cpl_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Assertions on tag use and completion
// stability, bound to the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mmio_cpl_sva (
    input logic                         clk,
    input logic                         reset_n,
    input logic                         req_valid,
    input mmio_cpl_pkg::mmio_host_req_t req,
    input logic                         rsp_valid,
    input mmio_cpl_pkg::mmio_afu_rsp_t  rsp,
    input logic                         rsp_ready,
    input logic                         cpl_valid,
    input mmio_cpl_pkg::cpl_beat_t      cpl,
    input logic                         cpl_ready
);

    // A tag is active from its request strobe until its completion leaves
    logic [mmio_cpl_pkg::MAX_OUTSTANDING_READS-1:0] tag_active;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tag_active <= '0;
        end
        else
        begin
            if (cpl_valid && cpl_ready)
                tag_active[cpl.hdr.tag] <= 1'b0;
            // A new request wins over a completion of the same tag
            if (req_valid)
                tag_active[req.tag] <= 1'b1;
        end
    end

    req_tag_free: assert property (@(posedge clk) disable iff (!reset_n)
        req_valid |-> !tag_active[req.tag])
        else $error("request for tag %0d while it is still active", req.tag);

    rsp_tag_active: assert property (@(posedge clk) disable iff (!reset_n)
        (rsp_valid && rsp_ready) |-> tag_active[rsp.tag])
        else $error("response accepted for inactive tag %0d", rsp.tag);

    // A stalled beat must not change or disappear
    cpl_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (cpl_valid && !cpl_ready) |=> (cpl_valid && $stable(cpl)))
        else $error("completion changed while the sink stalled");

endmodule

bind mmio_cpl_top mmio_cpl_sva mmio_cpl_sva_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready),
    .cpl_valid (cpl_valid),
    .cpl       (cpl),
    .cpl_ready (cpl_ready)
);

//--- sim/mmio_cpl_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top: stimulus table, LCG back-pressure,
// compare tasks, completion scoreboard and timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mmio_cpl_tb;

    // One host read and the accelerator answer for it
    typedef struct packed {
        int                      batch;
        mmio_cpl_pkg::mmio_tag_t tag;
        logic [15:0]             requester_id;
        logic [2:0]              tc;
        logic [6:0]              lower_addr;
        logic [11:0]             byte_count;
        logic [63:0]             payload;
        int                      rsp_order;
        logic                    bp;
    } stim_row_t;

    localparam int NUM_ROWS       = 13;
    localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 100;

    // Rows of a batch are requested together, then answered by rsp_order
    // Batch 0 and 1 are single reads, 2 is out of order, 3 adds back-pressure
    // and batch 4 reuses tags that completed earlier
    localparam stim_row_t STIM [NUM_ROWS] = '{
        '{0, 5'd3,  16'h0100, 3'd0, 7'h04, 12'd4, 64'h0000_0000_cafe_f00d, 0, 1'b0},
        '{1, 5'd17, 16'h0a21, 3'd2, 7'h08, 12'd8, 64'h0123_4567_89ab_cdef, 0, 1'b0},
        '{2, 5'd5,  16'h0310, 3'd1, 7'h10, 12'd4, 64'h0000_0000_5555_aaaa, 2, 1'b0},
        '{2, 5'd9,  16'h0311, 3'd7, 7'h18, 12'd8, 64'hdead_beef_0bad_f00d, 0, 1'b0},
        '{2, 5'd12, 16'h0312, 3'd3, 7'h2c, 12'd4, 64'h0000_0000_1234_5678, 3, 1'b0},
        '{2, 5'd30, 16'h0313, 3'd0, 7'h78, 12'd8, 64'hfedc_ba98_7654_3210, 1, 1'b0},
        '{3, 5'd0,  16'hbeef, 3'd4, 7'h00, 12'd8, 64'h1111_2222_3333_4444, 3, 1'b1},
        '{3, 5'd31, 16'h0001, 3'd5, 7'h3c, 12'd4, 64'h0000_0000_9999_8888, 1, 1'b1},
        '{3, 5'd7,  16'hff00, 3'd6, 7'h48, 12'd8, 64'ha5a5_5a5a_c3c3_3c3c, 0, 1'b1},
        '{3, 5'd21, 16'h7e57, 3'd1, 7'h64, 12'd4, 64'h0000_0000_0f0f_f0f0, 2, 1'b1},
        '{4, 5'd5,  16'h4401, 3'd2, 7'h20, 12'd8, 64'h0bad_cafe_0ddb_a11e, 1, 1'b1},
        '{4, 5'd3,  16'h4402, 3'd3, 7'h44, 12'd4, 64'h0000_0000_7777_6666, 2, 1'b1},
        '{4, 5'd17, 16'h4403, 3'd7, 7'h0c, 12'd4, 64'h0000_0000_abcd_ef01, 0, 1'b1}
    };

    logic                         clk;
    logic                         reset_n;
    logic                         req_valid;
    mmio_cpl_pkg::mmio_host_req_t req;
    logic                         rsp_valid;
    mmio_cpl_pkg::mmio_afu_rsp_t  rsp;
    logic                         rsp_ready;
    logic                         cpl_valid;
    mmio_cpl_pkg::cpl_beat_t      cpl;
    logic                         cpl_ready;

    // Expected beats in response acceptance order, cpl_count points at the next one
    mmio_cpl_pkg::cpl_beat_t exp_q [$];
    int                      cpl_count = 0;
    int                      cycle_count = 0;
    logic                    bp_on;
    logic [31:0]             lcg_state;

    tb_clock tb_clock_i (
        .clk     (clk),
        .reset_n (reset_n)
    );

    mmio_cpl_top mmio_cpl_top_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .cpl_valid (cpl_valid),
        .cpl       (cpl),
        .cpl_ready (cpl_ready)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Completion built from the rules for a CplD of 4 or 8 bytes
    function automatic mmio_cpl_pkg::cpl_beat_t expected_beat(input stim_row_t row);
        mmio_cpl_pkg::cpl_beat_t beat;
        beat                  = '0;
        beat.hdr.fmttype      = mmio_cpl_pkg::FMTTYPE_CPLD;
        beat.hdr.length       = 10'(row.byte_count / 12'd4);
        beat.hdr.byte_count   = row.byte_count;
        beat.hdr.requester_id = row.requester_id;
        beat.hdr.tc           = row.tc;
        beat.hdr.lower_addr   = row.lower_addr;
        beat.hdr.tag          = row.tag;
        beat.data             = row.payload;
        beat.dw_keep          = (row.byte_count == 12'd8) ? 2'b11 : 2'b01;
        return beat;
    endfunction

    task automatic check_hdr(input string what, input mmio_cpl_pkg::cpl_hdr_t got,
                             input mmio_cpl_pkg::cpl_hdr_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s header %h, expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "header compare");
        end
    endtask

    task automatic check_data(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s data %h, expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "data compare");
        end
    endtask

    task automatic check_keep(input string what, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s dw_keep %b, expected %b", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "dw_keep compare");
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "status compare");
        end
    endtask

    // Drive one request strobe on the next rising edge
    task automatic strobe_req(input int k);
        mmio_cpl_pkg::mmio_host_req_t r;
        r.tag          = STIM[k].tag;
        r.requester_id = STIM[k].requester_id;
        r.tc           = STIM[k].tc;
        r.lower_addr   = STIM[k].lower_addr;
        r.byte_count   = STIM[k].byte_count;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
    endtask

    // Called on a rising edge; returns on the edge where the response is taken
    task automatic send_rsp(input int k);
        mmio_cpl_pkg::mmio_afu_rsp_t r;
        r.tag     = STIM[k].tag;
        r.payload = STIM[k].payload;
        rsp_valid <= 1'b1;
        rsp       <= r;
        @(negedge clk);
        while (!rsp_ready)
            @(negedge clk);
        @(posedge clk);
        exp_q.push_back(expected_beat(STIM[k]));
    endtask

    task automatic run_batch(input int first, input int last);
        bp_on <= STIM[first].bp;
        for (int k = first; k <= last; k++)
            strobe_req(k);
        @(posedge clk);
        req_valid <= 1'b0;
        // Keeps every response at least two cycles behind its request
        repeat (2) @(posedge clk);
        for (int pos = 0; pos <= last - first; pos++)
        begin
            for (int k = first; k <= last; k++)
            begin
                if (STIM[k].rsp_order == pos)
                    send_rsp(k);
            end
        end
        rsp_valid <= 1'b0;
        // Tags of this batch may come back in the next one
        while (cpl_count < exp_q.size())
            @(posedge clk);
    endtask

    // Sink ready, random while back-pressure is on
    initial
    begin
        lcg_state = 32'ha3d3;
        cpl_ready <= 1'b1;
        forever
        begin
            @(posedge clk);
            lcg_state = lcg_step(lcg_state);
            cpl_ready <= bp_on ? lcg_state[16] : 1'b1;
        end
    end

    // Scoreboard; a transfer seen at the falling edge completes at the next rising one
    always @(negedge clk)
    begin
        if (reset_n && cpl_valid && cpl_ready)
        begin
            if (cpl_count >= exp_q.size())
            begin
                $display("Completion for tag %0d arrived with no response pending", cpl.hdr.tag);
                $display("Simulation FAILED");
                $fatal(1, "unexpected completion");
            end
            else
            begin
                check_hdr($sformatf("completion %0d", cpl_count), cpl.hdr, exp_q[cpl_count].hdr);
                check_data($sformatf("completion %0d", cpl_count), cpl.data,
                           exp_q[cpl_count].data);
                check_keep($sformatf("completion %0d", cpl_count), cpl.dw_keep,
                           exp_q[cpl_count].dw_keep);
                cpl_count <= cpl_count + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        int row;
        int last;
        req_valid <= 1'b0;
        req       <= '0;
        rsp_valid <= 1'b0;
        rsp       <= '0;
        bp_on     <= 1'b0;

        // Reset state, checked during reset and once right after it
        @(posedge clk);
        while (!reset_n)
        begin
            @(negedge clk);
            check_flag("cpl_valid around reset", cpl_valid, 1'b0);
            check_flag("rsp_ready around reset", rsp_ready, 1'b1);
        end

        row = 0;
        while (row < NUM_ROWS)
        begin
            last = row;
            while (last + 1 < NUM_ROWS && STIM[last + 1].batch == STIM[row].batch)
                last++;
            run_batch(row, last);
            row = last + 1;
        end

        // A few idle cycles let a stray extra completion show up
        repeat (5) @(posedge clk);
        if (exp_q.size() == NUM_ROWS && cpl_count == exp_q.size())
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
        begin
            $display("Saw %0d completions for %0d accepted responses", cpl_count, exp_q.size());
            $display("Simulation FAILED");
            $fatal(1, "completion count");
        end
    end

endmodule

//--- list.f
design/mmio_cpl_pkg.sv
design/sync_fifo2.sv
design/mmio_req_track.sv
design/mmio_cpl_build.sv
design/mmio_cpl_top.sv
sim/tb_clock.sv
sim/mmio_cpl_sva.sv
sim/mmio_cpl_tb.sv

//--- Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing -Wall --timescale 1ns/1ps
TOP        = mmio_cpl_tb
FILE_LIST  = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# The log decides the result, a nonzero exit of the model also fails the run
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation FAILED" $(LOG); then exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
